// File: Bender.yml
package:
  name: histogram

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/histogram_pkg.sv
      - verilog/true_dual_port_ram.sv
      - verilog/histogram_control.sv
      - verilog/histogram_update.sv
      - verilog/histogram_access.sv
      - verilog/histogram_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/histogram_tb.sv

// File: project.f
+incdir+verilog
verilog/histogram_pkg.sv
verilog/true_dual_port_ram.sv
verilog/histogram_control.sv
verilog/histogram_update.sv
verilog/histogram_access.sv
verilog/histogram_top.sv
test/histogram_tb.sv

// File: test/histogram_tb.sv
`include "histogram_defs.svh"

module histogram_tb import histogram_pkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD         = 40;
  localparam int BINS           = `HIST_BIN_COUNT;
  localparam int RANDOM_SAMPLES = 400;
  localparam int HEAVY_SAMPLES  = 10000;
  localparam int QUIET_SAMPLES  = 200;
  // Six full readouts, three clears, plus config writes and slack
  localparam int TOTAL_CYCLES   = 5 + RANDOM_SAMPLES + 2 * HEAVY_SAMPLES + QUIET_SAMPLES
                                  + 6 * 2 * BINS + 3 * (BINS + 4) + 500;
  localparam int WATCHDOG_NS    = TOTAL_CYCLES * PERIOD;

  logic       clock;
  logic       rst_n;
  logic       sample_valid;
  bin_index_t sample_bin;
  logic       cfg_write;
  logic       cfg_enable;
  logic       cfg_saturate;
  logic       cfg_clear;
  logic       host_read;
  bin_index_t host_bin;
  logic       host_read_valid;
  count_t     host_read_data;
  logic       busy;

  // Reference counts and the last configuration written
  count_t     model [BINS];
  logic       cur_enable;
  logic       cur_saturate;
  int         seed;

  histogram_top i_dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .sample_valid   (sample_valid),
    .sample_bin     (sample_bin),
    .cfg_write      (cfg_write),
    .cfg_enable     (cfg_enable),
    .cfg_saturate   (cfg_saturate),
    .cfg_clear      (cfg_clear),
    .host_read      (host_read),
    .host_bin       (host_bin),
    .host_read_valid(host_read_valid),
    .host_read_data (host_read_data),
    .busy           (busy)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  task automatic stop_run;
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_count(string name, count_t expected, count_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  // Inputs change shortly after the rising edge
  task automatic next_cycle;
    @(posedge clock);
    #2;
  endtask

  // Hold at max when saturating, otherwise roll over
  function automatic count_t bumped(count_t value, logic saturate);
    if (saturate && value == '1) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  // Settings take effect in the following cycle
  task automatic write_config(logic enable, logic saturate);
    next_cycle();
    cfg_write    = 1'b1;
    cfg_enable   = enable;
    cfg_saturate = saturate;
    next_cycle();
    cfg_write    = 1'b0;
    cur_enable   = enable;
    cur_saturate = saturate;
  endtask

  task automatic wait_idle;
    @(negedge clock);
    while (busy) begin
      @(negedge clock);
    end
  endtask

  // One accepted host read with valid exactly one cycle after the strobe
  task automatic read_bin(bin_index_t bin);
    next_cycle();
    host_read = 1'b1;
    host_bin  = bin;
    @(negedge clock);
    check_flag("host_read_valid", 1'b0, host_read_valid);
    next_cycle();
    host_read = 1'b0;
    @(negedge clock);
    check_flag("host_read_valid", 1'b1, host_read_valid);
    check_count($sformatf("host_read_data[%0d]", bin), model[bin], host_read_data);
  endtask

  task automatic readout_all;
    wait_idle();
    for (int b = 0; b < BINS; b++) begin
      read_bin(bin_index_t'(b));
    end
  endtask

  // Read that must be ignored and give no valid pulse
  task automatic rejected_read;
    next_cycle();
    host_read = 1'b1;
    host_bin  = bin_index_t'($random(seed));
    @(negedge clock);
    check_flag("host_read_valid", 1'b0, host_read_valid);
    next_cycle();
    host_read = 1'b0;
    @(negedge clock);
    check_flag("host_read_valid", 1'b0, host_read_valid);
  endtask

  // Heavy mode aims most samples at bins 5 and 11
  // A quarter of the samples repeat the previous bin back to back
  task automatic send_samples(int count, bit heavy);
    logic [31:0] r;
    bin_index_t  b;
    bin_index_t  last;
    last = '0;
    for (int i = 0; i < count; i++) begin
      r = $unsigned($random(seed));
      if (r % 4 == 0) begin
        b = last;
      end else if (heavy && r[7:4] != 4'd0) begin
        b = r[9] ? bin_index_t'(5) : bin_index_t'(11);
      end else begin
        b = bin_index_t'(r[19:16]);
      end
      next_cycle();
      sample_valid = 1'b1;
      sample_bin   = b;
      if (cur_enable) begin
        model[b] = bumped(model[b], cur_saturate);
      end
      last = b;
    end
    next_cycle();
    sample_valid = 1'b0;
  endtask

  // Clear request with host reads and optional samples during the sweep
  task automatic clear_bins(bit traffic);
    int busy_cycles;
    next_cycle();
    cfg_clear    = 1'b1;
    sample_valid = traffic;
    sample_bin   = bin_index_t'($random(seed));
    @(negedge clock);
    check_flag("busy", 1'b1, busy);
    busy_cycles = 1;
    do begin
      next_cycle();
      cfg_clear    = 1'b0;
      sample_valid = traffic && busy_cycles < BINS;
      host_read    = busy_cycles < BINS;
      sample_bin   = bin_index_t'($random(seed));
      host_bin     = bin_index_t'($random(seed));
      @(negedge clock);
      check_flag("host_read_valid", 1'b0, host_read_valid);
      if (busy) begin
        busy_cycles++;
      end
    end while (busy);
    // Request cycle plus one write per bin at least
    if (busy_cycles < BINS + 1) begin
      $display("Clear sweep ended after only %0d busy cycles", busy_cycles);
      stop_run();
    end
    for (int b = 0; b < BINS; b++) begin
      model[b] = '0;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
    stop_run();
  end

  initial begin
    seed         = 32'ha64d;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample_bin   = '0;
    cfg_write    = 1'b0;
    cfg_enable   = 1'b0;
    cfg_saturate = 1'b0;
    cfg_clear    = 1'b0;
    host_read    = 1'b0;
    host_bin     = '0;
    cur_enable   = 1'b0;
    cur_saturate = 1'b0;
    repeat (5) @(posedge clock);
    #2;
    rst_n = 1'b1;
    @(negedge clock);
    check_flag("busy", 1'b0, busy);
    check_flag("host_read_valid", 1'b0, host_read_valid);

    // Initial clear leaves every bin at zero
    clear_bins(1'b0);
    readout_all();

    // Random traffic in wrap mode through the forwarding path
    write_config(1'b1, 1'b0);
    send_samples(RANDOM_SAMPLES, 1'b0);
    rejected_read();
    write_config(1'b0, 1'b0);
    readout_all();

    // Hot bins pinned at the maximum in saturate mode
    clear_bins(1'b0);
    write_config(1'b1, 1'b1);
    send_samples(HEAVY_SAMPLES, 1'b1);
    write_config(1'b0, 1'b1);
    readout_all();

    // Hot bins roll over back in wrap mode
    write_config(1'b1, 1'b0);
    send_samples(HEAVY_SAMPLES, 1'b1);
    write_config(1'b0, 1'b0);
    readout_all();

    // Disabled traffic leaves the counts alone
    send_samples(QUIET_SAMPLES, 1'b0);
    readout_all();

    // Samples and host reads during a clear are dropped
    write_config(1'b1, 1'b0);
    clear_bins(1'b1);
    rejected_read();
    write_config(1'b0, 1'b0);
    readout_all();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog/histogram_access.sv
module histogram_access import histogram_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  // Update pipeline requests
  input  logic       update_read,
  input  bin_index_t update_read_bin,
  input  logic       update_write,
  input  bin_index_t update_write_bin,
  input  count_t     update_write_count,
  // Clear sweep
  input  logic       clear_active,
  input  bin_index_t clear_bin,
  // Host read
  input  logic       host_idle,
  input  logic       host_read,
  input  bin_index_t host_bin,
  // RAM port 0 read data
  input  count_t     ram_read_data,
  // RAM port 0, read only
  output logic       ram_0_enable,
  output bin_index_t ram_0_address,
  // RAM port 1, write only
  output logic       ram_1_enable,
  output bin_index_t ram_1_address,
  output count_t     ram_1_data,
  // Host result
  output logic       host_read_valid,
  output count_t     host_read_data
);

  // Host read taken only when idle
  logic host_accept;

  assign host_accept = host_read & host_idle;

  // Port 0 owners
  // Update owns it while counting, host while idle
  assign ram_0_enable  = update_read | host_accept;
  assign ram_0_address = update_read ? update_read_bin : host_bin;

  // Port 1 owners
  // Clear sweep has priority, update pipeline is drained by then
  assign ram_1_enable  = clear_active | update_write;
  assign ram_1_address = clear_active ? clear_bin : update_write_bin;
  assign ram_1_data    = clear_active ? count_t'(0) : update_write_count;

  // Valid follows the accepted read by one cycle, with the RAM output
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      host_read_valid <= 1'b0;
    end else begin
      host_read_valid <= host_accept;
    end
  end

  // Data only meaningful with valid
  // Zero otherwise so the host never sees update traffic
  assign host_read_data = host_read_valid ? ram_read_data : count_t'(0);

  // Control keeps host and update off port 0 at the same time
  assert property (@(posedge clock) disable iff (!rst_n)
    !(update_read && host_accept));

endmodule

// File: verilog/histogram_control.sv
`include "histogram_defs.svh"

module histogram_control import histogram_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  // Configuration strobes
  input  logic       cfg_write,
  input  logic       cfg_enable,
  input  logic       cfg_saturate,
  input  logic       cfg_clear,
  // Update pipeline status
  input  logic       pipeline_active,
  // Settings to the datapath
  output logic       count_enable,
  output logic       saturate_mode,
  // Clear sweep
  output logic       clear_active,
  output bin_index_t clear_bin,
  // Status
  output logic       host_idle,
  output logic       busy
);

  localparam bin_index_t LAST_BIN = bin_index_t'(`HIST_LAST_BIN);

  // Stored enable setting
  logic enable_q;
  // Clear requested and waiting for the pipeline to drain
  logic clear_pending;
  // Sweep may begin this cycle
  logic clear_start;

  // Configuration registers loaded on cfg_write
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      enable_q      <= 1'b0;
      saturate_mode <= 1'b0;
    end else if (cfg_write) begin
      enable_q      <= cfg_enable;
      saturate_mode <= cfg_saturate;
    end
  end

  // Sweep waits until no update is in flight
  assign clear_start = clear_pending & ~clear_active & ~pipeline_active;

  // Pending flag
  // A new request during a sweep restarts it afterwards
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      clear_pending <= 1'b0;
    end else if (cfg_clear) begin
      clear_pending <= 1'b1;
    end else if (clear_start) begin
      clear_pending <= 1'b0;
    end
  end

  // Sweep counter steps one bin per cycle from bin 0
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      clear_active <= 1'b0;
      clear_bin    <= '0;
    end else if (clear_start) begin
      clear_active <= 1'b1;
      clear_bin    <= '0;
    end else if (clear_active) begin
      if (clear_bin == LAST_BIN) begin
        clear_active <= 1'b0;
        clear_bin    <= '0;
      end else begin
        clear_bin <= clear_bin + 1'b1;
      end
    end
  end

  // Samples blocked from the request cycle onwards
  assign count_enable = enable_q & ~cfg_clear & ~clear_pending & ~clear_active;

  // Busy covers request cycle, wait, sweep and in-flight updates
  assign busy = cfg_clear | clear_pending | clear_active | pipeline_active;

  // Host may read only with counting off and nothing in progress
  assign host_idle = ~enable_q & ~busy;

  // Sweep never shares port 1 with an update write
  assert property (@(posedge clock) disable iff (!rst_n)
    clear_active |-> !pipeline_active);

endmodule

// File: verilog/histogram_defs.svh
`ifndef HISTOGRAM_DEFS_SVH
`define HISTOGRAM_DEFS_SVH

// Number of histogram bins
// Also the RAM depth and the clear sweep length
`define HIST_BIN_COUNT 16

// Bits in one bin count
`define HIST_COUNT_WIDTH 12

// Bin index width, follows the bin count
`define HIST_BIN_WIDTH $clog2(`HIST_BIN_COUNT)

// Last valid bin index
`define HIST_LAST_BIN (`HIST_BIN_COUNT - 1)

`endif

// File: verilog/histogram_pkg.sv
`include "histogram_defs.svh"

package histogram_pkg;

  // Index of one histogram bin
  typedef logic [`HIST_BIN_WIDTH-1:0] bin_index_t;

  // One bin count, as stored in the RAM
  typedef logic [`HIST_COUNT_WIDTH-1:0] count_t;

endpackage

// File: verilog/histogram_top.sv
`include "histogram_defs.svh"

module histogram_top import histogram_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  // Sample stream
  input  logic       sample_valid,
  input  bin_index_t sample_bin,
  // Configuration
  input  logic       cfg_write,
  input  logic       cfg_enable,
  input  logic       cfg_saturate,
  input  logic       cfg_clear,
  // Host read
  input  logic       host_read,
  input  bin_index_t host_bin,
  output logic       host_read_valid,
  output count_t     host_read_data,
  // Status
  output logic       busy
);

  // Control outputs
  logic       count_enable;
  logic       saturate_mode;
  logic       clear_active;
  bin_index_t clear_bin;
  logic       host_idle;

  // Update pipeline outputs
  logic       update_read;
  bin_index_t update_read_bin;
  logic       update_write;
  bin_index_t update_write_bin;
  count_t     update_write_count;
  logic       pipeline_active;

  // RAM port signals
  logic       ram_0_enable;
  bin_index_t ram_0_address;
  count_t     ram_read_data;
  logic       ram_1_enable;
  bin_index_t ram_1_address;
  count_t     ram_1_data;

  // Settings, clear sweep, status
  histogram_control control (
    .clock          (clock),
    .rst_n          (rst_n),
    .cfg_write      (cfg_write),
    .cfg_enable     (cfg_enable),
    .cfg_saturate   (cfg_saturate),
    .cfg_clear      (cfg_clear),
    .pipeline_active(pipeline_active),
    .count_enable   (count_enable),
    .saturate_mode  (saturate_mode),
    .clear_active   (clear_active),
    .clear_bin      (clear_bin),
    .host_idle      (host_idle),
    .busy           (busy)
  );

  // Read-increment-write pipeline
  histogram_update update (
    .clock             (clock),
    .rst_n             (rst_n),
    .sample_valid      (sample_valid),
    .sample_bin        (sample_bin),
    .count_enable      (count_enable),
    .saturate_mode     (saturate_mode),
    .read_count        (ram_read_data),
    .update_read       (update_read),
    .update_read_bin   (update_read_bin),
    .update_write      (update_write),
    .update_write_bin  (update_write_bin),
    .update_write_count(update_write_count),
    .pipeline_active   (pipeline_active)
  );

  // Port steering and host readout
  histogram_access access (
    .clock             (clock),
    .rst_n             (rst_n),
    .update_read       (update_read),
    .update_read_bin   (update_read_bin),
    .update_write      (update_write),
    .update_write_bin  (update_write_bin),
    .update_write_count(update_write_count),
    .clear_active      (clear_active),
    .clear_bin         (clear_bin),
    .host_idle         (host_idle),
    .host_read         (host_read),
    .host_bin          (host_bin),
    .ram_read_data     (ram_read_data),
    .ram_0_enable      (ram_0_enable),
    .ram_0_address     (ram_0_address),
    .ram_1_enable      (ram_1_enable),
    .ram_1_address     (ram_1_address),
    .ram_1_data        (ram_1_data),
    .host_read_valid   (host_read_valid),
    .host_read_data    (host_read_data)
  );

  // Bin storage
  // Port 0 tied to read, port 1 tied to write
  true_dual_port_ram #(
    .WIDTH(`HIST_COUNT_WIDTH),
    .DEPTH(`HIST_BIN_COUNT)
  ) bin_ram (
    .clock               (clock),
    .port_0_access_enable(ram_0_enable),
    .port_0_write        (1'b0),
    .port_0_address      (ram_0_address),
    .port_0_write_data   (count_t'(0)),
    .port_0_read_data    (ram_read_data),
    .port_1_access_enable(ram_1_enable),
    .port_1_write        (1'b1),
    .port_1_address      (ram_1_address),
    .port_1_write_data   (ram_1_data),
    .port_1_read_data    ()
  );

endmodule

// File: verilog/histogram_update.sv
module histogram_update import histogram_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  // Sample stream
  input  logic       sample_valid,
  input  bin_index_t sample_bin,
  // Settings from control
  input  logic       count_enable,
  input  logic       saturate_mode,
  // RAM port 0 read data one cycle after the read
  input  count_t     read_count,
  // Read request for port 0
  output logic       update_read,
  output bin_index_t update_read_bin,
  // Write request for port 1
  output logic       update_write,
  output bin_index_t update_write_bin,
  output count_t     update_write_count,
  // Stage 2 occupied
  output logic       pipeline_active
);

  localparam count_t COUNT_MAX = '1;

  // Stage 1 accept
  logic       sample_accept;

  // Stage 2 state
  logic       stage_2_valid;
  bin_index_t stage_2_bin;

  // Last written word for the read that missed it
  logic       forward_valid;
  bin_index_t forward_bin;
  count_t     forward_count;

  // Count before and after the increment
  logic       forward_hit;
  count_t     base_count;
  count_t     next_count;

  // Stage 1
  // Gate the sample and launch the RAM read in the same cycle
  assign sample_accept   = sample_valid & count_enable;
  assign update_read     = sample_accept;
  assign update_read_bin = sample_bin;

  // Stage 1 to stage 2 valid
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      stage_2_valid <= 1'b0;
    end else begin
      stage_2_valid <= sample_accept;
    end
  end

  // Stage 2 bin
  always_ff @(posedge clock) begin
    if (sample_accept) begin
      stage_2_bin <= sample_bin;
    end
  end

  // Forwarding register
  // Previous write commits on the same edge as the current read,
  // so the RAM returns the stale word for that bin
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      forward_valid <= 1'b0;
    end else begin
      forward_valid <= update_write;
    end
  end

  always_ff @(posedge clock) begin
    if (update_write) begin
      forward_bin   <= update_write_bin;
      forward_count <= update_write_count;
    end
  end

  // Stage 2
  // Pick forwarded count on a back-to-back hit
  assign forward_hit = forward_valid & (forward_bin == stage_2_bin);
  assign base_count  = forward_hit ? forward_count : read_count;

  // Increment that holds at max in saturate mode and rolls over otherwise
  always_comb begin
    if (saturate_mode && base_count == COUNT_MAX) begin
      next_count = COUNT_MAX;
    end else begin
      next_count = base_count + 1'b1;
    end
  end

  // Write back on port 1
  assign update_write       = stage_2_valid;
  assign update_write_bin   = stage_2_bin;
  assign update_write_count = next_count;
  assign pipeline_active    = stage_2_valid;

  // Back-to-back writes to one bin step by one in wrap mode
  assert property (@(posedge clock) disable iff (!rst_n)
    update_write && $past(update_write) && !saturate_mode &&
    update_write_bin == $past(update_write_bin)
    |-> update_write_count == count_t'($past(update_write_count) + 1'b1));

endmodule

// File: verilog/true_dual_port_ram.sv
module true_dual_port_ram #(
  parameter int WIDTH         = 8,
  parameter int DEPTH         = 16,
  parameter int ADDRESS_WIDTH = $clog2(DEPTH)
) (
  input  logic                     clock,
  // Port 0
  input  logic                     port_0_access_enable,
  input  logic                     port_0_write,
  input  logic [ADDRESS_WIDTH-1:0] port_0_address,
  input  logic [WIDTH-1:0]         port_0_write_data,
  output logic [WIDTH-1:0]         port_0_read_data,
  // Port 1
  input  logic                     port_1_access_enable,
  input  logic                     port_1_write,
  input  logic [ADDRESS_WIDTH-1:0] port_1_address,
  input  logic [WIDTH-1:0]         port_1_write_data,
  output logic [WIDTH-1:0]         port_1_read_data
);

  // Storage array, no reset
  logic [WIDTH-1:0] memory [DEPTH];

  // Per-port access decode
  logic port_0_write_enable;
  logic port_0_read_enable;
  logic port_1_write_enable;
  logic port_1_read_enable;

  assign port_0_write_enable = port_0_access_enable & port_0_write;
  assign port_0_read_enable  = port_0_access_enable & ~port_0_write;
  assign port_1_write_enable = port_1_access_enable & port_1_write;
  assign port_1_read_enable  = port_1_access_enable & ~port_1_write;

  // Writes from either port
  // Same-address writes on both ports in one cycle are undefined
  always_ff @(posedge clock) begin
    if (port_0_write_enable) begin
      memory[port_0_address] <= port_0_write_data;
    end
    if (port_1_write_enable) begin
      memory[port_1_address] <= port_1_write_data;
    end
  end

  // Registered reads, holding register keeps last word
  // A read colliding with a write on the other port returns the old word
  always_ff @(posedge clock) begin
    if (port_0_read_enable) begin
      port_0_read_data <= memory[port_0_address];
    end
    if (port_1_read_enable) begin
      port_1_read_data <= memory[port_1_address];
    end
  end

endmodule
